// ==== list.f ====
+incdir+design
+incdir+verification
design/rv_isa_pkg.sv
design/lsu_pkg.sv
design/agu.sv
design/store_align.sv
design/load_extend.sv
design/data_ram.sv
design/lsu_ctrl.sv
design/lsu_top.sv
verification/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module lsu_tb --Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/lsu_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'Result: PASSED'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== verification/lsu_tests.svh ====
`ifndef LSU_TESTS_SVH
`define LSU_TESTS_SVH

task automatic word_store_load();
  int errors_before;
  errors_before = errors;
  for (int i = 0; i < 8; i++) begin
    run_op(op_sw, '0, 32'h100, i * 20, next_random(), 0);
  end
  for (int i = 0; i < 8; i++) begin
    run_op(op_lw, '0, 32'h100, i * 20, '0, 0);
  end
  finish_test("word store and load", errors_before);
endtask

task automatic sub_word_access();
  logic [7:0] lanes [4] = '{8'h81, 8'h22, 8'hc3, 8'h44};
  int         errors_before;
  errors_before = errors;
  run_op(op_sw, '0, 32'h200, 0, '0, 0);
  // upper bits of wdata must not leak into other lanes
  for (int k = 0; k < 4; k++) begin
    run_op(op_sb, '0, 32'h200, k, {24'hdeadbe, lanes[k]}, 0);
  end
  run_op(op_lw, '0, 32'h200, 0, '0, 0);
  run_op(op_sh, '0, 32'h1fc, 8, 32'h1234_8a5b, 0);
  run_op(op_sh, '0, 32'h204, 2, 32'h5678_f0e1, 0);
  run_op(op_lw, '0, 32'h204, 0, '0, 0);
  for (int k = 0; k < 4; k++) begin
    run_op(op_lb, '0, 32'h200, k, '0, 0);
    run_op(op_lbu, '0, 32'h200, k, '0, 0);
  end
  run_op(op_lh, '0, 32'h204, 0, '0, 0);
  run_op(op_lhu, '0, 32'h204, 0, '0, 0);
  run_op(op_lh, '0, 32'h204, 2, '0, 0);
  run_op(op_lhu, '0, 32'h204, 2, '0, 0);
  finish_test("sub-word access", errors_before);
endtask

task automatic misalign_faults();
  int errors_before;
  errors_before = errors;
  run_op(op_sw, '0, 32'h300, 0, 32'h5a5a_1234, 0);
  for (int k = 1; k < 4; k++) begin
    run_op(op_lw, '0, 32'h300, k, '0, 0);
    run_op(op_sw, '0, 32'h300, k, 32'hffff_ffff, 0);
  end
  run_op(op_lh, '0, 32'h305, -4, '0, 0);
  run_op(op_lhu, '0, 32'h300, 3, '0, 0);
  run_op(op_sh, '0, 32'h300, 1, 32'hffff_ffff, 0);
  run_op(op_sh, '0, 32'h300, 3, 32'hffff_ffff, 0);
  // word untouched by the faulting stores
  run_op(op_lw, '0, 32'h300, 0, '0, 0);
  finish_test("misalignment", errors_before);
endtask

task automatic jump_addressing();
  int errors_before;
  errors_before = errors;
  run_op(op_jal, 32'h1000, 32'hffff_0000, 32'h24, '0, 0);
  run_op(op_jal, 32'h1000, '0, 32'h22, '0, 0);
  run_op(op_branch, 32'h2000, 32'h5555, -8, '0, 0);
  run_op(op_branch, 32'h2000, '0, 32'h6, '0, 0);
  run_op(op_jalr, 32'h9000, 32'h3001, 32'h10, '0, 0);
  run_op(op_jalr, 32'h9000, 32'h3000, 32'h3, '0, 0);
  for (int k = 0; k < 4; k++) begin
    run_op(op_auipc, 32'h4000, 32'h7777, k, '0, 0);
  end
  finish_test("jump and auipc addressing", errors_before);
endtask

task automatic back_pressure();
  int errors_before;
  errors_before = errors;
  run_op(op_sw, '0, 32'h3c0, 0, 32'h0bad_cafe, 4);
  run_op(op_lw, '0, 32'h3c0, 0, '0, 5);
  run_op(op_jalr, '0, 32'h3c0, 4, '0, 3);
  run_op(op_lh, '0, 32'h3c0, 1, '0, 2);
  finish_test("back-pressure", errors_before);
endtask

task automatic random_traffic();
  word_t      r;
  word_t      pc_val;
  word_t      data_val;
  logic [3:0] sel;
  int         errors_before;
  errors_before = errors;
  // window of 16 words, every load in it has a known value
  for (int w = 0; w < 16; w++) begin
    run_op(op_sw, '0, 32'h380, w * 4, next_random(), 0);
  end
  for (int n = 0; n < 200; n++) begin
    r = next_random();
    pc_val = next_random();
    data_val = next_random();
    sel = r[19:16] % 4'd12;
    run_op(mem_op_e'(sel), pc_val, 32'h380 + word_t'(r[28:24]), word_t'(r[12:8]),
           data_val, -1);
  end
  finish_test("random traffic", errors_before);
endtask

`endif

// ==== verification/lsu_tb.sv ====
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_tb;
  import rv_isa_pkg::*;

  typedef logic [`LSU_XLEN-1:0] word_t;

  // about 300 transactions of at most 5 cycles, plus margin
  localparam int timeout_cycles = 300 * 5 + 500;

  logic       clock = 1'b0;
  logic       rst = 1'b1;
  logic       req_valid = 1'b0;
  logic       req_ready;
  mem_op_e    req_op = op_lw;
  word_t      req_pc = '0;
  word_t      req_rs1 = '0;
  word_t      req_imm = '0;
  word_t      req_wdata = '0;
  logic       rsp_valid;
  logic       rsp_ready = 1'b0;
  word_t      rsp_value;
  logic       rsp_exception;
  exc_cause_e rsp_ecause;
  word_t      rsp_etval;

  word_t ref_mem [`LSU_RAM_WORDS];
  word_t lcg_state = 32'hdc16;
  int    errors = 0;
  int    checks = 0;
  int    tests_run = 0;
  int    cycle_count = 0;

  lsu_top dut0 (.*);

  initial begin
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic word_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string what, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL t=%0t: %s expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    $display("test %s done, %0d errors", name, errors - errors_before);
  endtask

  // expected response from the address and extension rules, updates ref_mem on stores
  task automatic predict_response(
    input  mem_op_e    op,
    input  word_t      pc,
    input  word_t      rs1,
    input  word_t      imm,
    input  word_t      wdata,
    output word_t      value,
    output logic       exc,
    output exc_cause_e cause,
    output word_t      addr,
    output int         latency
  );
    word_t ea;
    word_t word;
    int    idx;
    int    lane;
    logic  load;

    ea = ((op inside {op_jal, op_branch, op_auipc}) ? pc : rs1) + imm;
    if (op == op_jalr) begin
      ea[0] = 1'b0;
    end
    addr = ea;
    idx = int'(ea[`LSU_RAM_AW+1:2]);
    lane = int'(ea[1:0]);
    word = ref_mem[idx] >> (lane * 8);
    load = op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    case (op)
      op_lh, op_lhu, op_sh: exc = ea[0];
      op_lw, op_sw, op_jal, op_jalr, op_branch: exc = (ea[1:0] != 2'b00);
      default: exc = 1'b0;
    endcase
    cause = exc_instr_misalign;
    if (load) begin
      cause = exc_load_misalign;
    end else if (op inside {op_sb, op_sh, op_sw}) begin
      cause = exc_store_misalign;
    end
    latency = (load && !exc) ? 2 : 1;
    value = '0;
    if (!exc) begin
      case (op)
        op_sb: ref_mem[idx][lane*8 +: 8] = wdata[7:0];
        op_sh: ref_mem[idx][lane*8 +: 16] = wdata[15:0];
        op_sw: ref_mem[idx] = wdata;
        op_lb: value = {{24{word[7]}}, word[7:0]};
        op_lbu: value = {24'h0, word[7:0]};
        op_lh: value = {{16{word[15]}}, word[15:0]};
        op_lhu: value = {16'h0, word[15:0]};
        op_lw: value = word;
        default: value = ea;
      endcase
    end
  endtask

  // hold >= 0 stalls rsp_ready that many cycles, hold < 0 drives it at random
  task automatic run_op(
    input mem_op_e op,
    input word_t   pc,
    input word_t   rs1,
    input word_t   imm,
    input word_t   wdata,
    input int      hold
  );
    word_t      exp_value;
    logic       exp_exc;
    exc_cause_e exp_cause;
    word_t      exp_addr;
    int         exp_latency;
    word_t      held_value;
    word_t      rnd;
    int         waited;
    int         stalls;
    bit         seen;
    bit         done;

    predict_response(op, pc, rs1, imm, wdata, exp_value, exp_exc, exp_cause, exp_addr,
                     exp_latency);
    rnd = next_random();
    req_valid <= 1'b1;
    req_op <= op;
    req_pc <= pc;
    req_rs1 <= rs1;
    req_imm <= imm;
    req_wdata <= wdata;
    rsp_ready <= (hold < 0) ? rnd[16] : (hold == 0);

    waited = 0;
    do begin
      @(posedge clock);
      waited++;
    end while (!req_ready && waited < 16);
    req_valid <= 1'b0;
    if (!req_ready) begin
      errors++;
      $display("t=%0t: %s request was never accepted", $time, op.name());
    end else begin
      check_value("accept delay", 1, waited);
      waited = 0;
      stalls = 0;
      seen = 1'b0;
      done = 1'b0;
      while (!done) begin
        @(posedge clock);
        waited++;
        rnd = next_random();
        if (rsp_valid) begin
          if (!seen) begin
            seen = 1'b1;
            held_value = rsp_value;
            check_value("response latency", exp_latency, waited);
            check_value("rsp_value", exp_value, rsp_value);
            check_value("rsp_exception", 32'(exp_exc), 32'(rsp_exception));
            if (exp_exc) begin
              check_value("rsp_ecause", 32'(exp_cause), 32'(rsp_ecause));
              check_value("rsp_etval", exp_addr, rsp_etval);
            end
          end else begin
            check_value("rsp_value under stall", held_value, rsp_value);
          end
          check_value("req_ready with response pending", 0, 32'(req_ready));
          if (rsp_ready) begin
            done = 1'b1;
          end else begin
            stalls++;
            rsp_ready <= (hold < 0) ? (rnd[16] | (stalls >= 2)) : (stalls >= hold);
          end
        end else if (waited > 8) begin
          errors++;
          $display("t=%0t: %s request got no response", $time, op.name());
          done = 1'b1;
        end else begin
          check_value("req_ready while busy", 0, 32'(req_ready));
          if (hold < 0) begin
            rsp_ready <= rnd[16];
          end
        end
      end
    end
  endtask

  `include "lsu_tests.svh"

  initial begin
    repeat (8) @(posedge clock);
    rst <= 1'b0;
    @(posedge clock);
    check_value("req_ready after reset", 1, 32'(req_ready));
    check_value("rsp_valid after reset", 0, 32'(rsp_valid));
    word_store_load();
    sub_word_access();
    misalign_faults();
    jump_addressing();
    back_pressure();
    random_traffic();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== design/lsu_top.sv ====
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_top (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  rv_isa_pkg::mem_op_e    req_op,
  input  logic [`LSU_XLEN-1:0]   req_pc,
  input  logic [`LSU_XLEN-1:0]   req_rs1,
  input  logic [`LSU_XLEN-1:0]   req_imm,
  input  logic [`LSU_XLEN-1:0]   req_wdata,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output logic [`LSU_XLEN-1:0]   rsp_value,
  output logic                   rsp_exception,
  output rv_isa_pkg::exc_cause_e rsp_ecause,
  output logic [`LSU_XLEN-1:0]   rsp_etval
);
  import rv_isa_pkg::*;
  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0]   agu_address;
  logic [3:0]             agu_byteenable;
  logic                   agu_exception;
  exc_cause_e             agu_ecause;
  logic [`LSU_XLEN-1:0]   agu_etval;
  access_size_e           size;
  logic [1:0]             offset;
  access_size_e           reg_size;
  logic                   reg_unsigned;
  logic [1:0]             reg_offset;
  logic [`LSU_XLEN-1:0]   lane_data;
  logic [`LSU_XLEN-1:0]   load_value;
  logic                   ram_we;
  logic [3:0]             ram_be;
  logic                   ram_re;
  logic [`LSU_RAM_AW-1:0] ram_addr;
  logic [`LSU_XLEN-1:0]   ram_wdata;
  logic [`LSU_XLEN-1:0]   ram_rdata;

  agu u_agu (
    .op         (req_op),
    .pc         (req_pc),
    .rs1        (req_rs1),
    .imm        (req_imm),
    .address    (agu_address),
    .byteenable (agu_byteenable),
    .exception  (agu_exception),
    .ecause     (agu_ecause),
    .etval      (agu_etval)
  );

  store_align u_store_align (
    .size      (size),
    .offset    (offset),
    .wdata     (req_wdata),
    .lane_data (lane_data)
  );

  load_extend u_load_extend (
    .size        (reg_size),
    .is_unsigned (reg_unsigned),
    .offset      (reg_offset),
    .rdata       (ram_rdata),
    .value       (load_value)
  );

  data_ram u_data_ram (
    .clock      (clock),
    .we         (ram_we),
    .byteenable (ram_be),
    .re         (ram_re),
    .addr       (ram_addr),
    .wdata      (ram_wdata),
    .rdata      (ram_rdata)
  );

  lsu_ctrl u_lsu_ctrl (
    .clock         (clock),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp_value     (rsp_value),
    .rsp_exception (rsp_exception),
    .rsp_ecause    (rsp_ecause),
    .rsp_etval     (rsp_etval),
    .op            (req_op),
    .address       (agu_address),
    .byteenable    (agu_byteenable),
    .exception     (agu_exception),
    .ecause        (agu_ecause),
    .etval         (agu_etval),
    .lane_data     (lane_data),
    .load_value    (load_value),
    .size          (size),
    .offset        (offset),
    .reg_size      (reg_size),
    .reg_unsigned  (reg_unsigned),
    .reg_offset    (reg_offset),
    .ram_we        (ram_we),
    .ram_be        (ram_be),
    .ram_re        (ram_re),
    .ram_addr      (ram_addr),
    .ram_wdata     (ram_wdata)
  );

endmodule

// ==== design/lsu_ctrl.sv ====
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsu_ctrl (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   req_valid,
  output logic                   req_ready,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output logic [`LSU_XLEN-1:0]   rsp_value,
  output logic                   rsp_exception,
  output rv_isa_pkg::exc_cause_e rsp_ecause,
  output logic [`LSU_XLEN-1:0]   rsp_etval,
  input  rv_isa_pkg::mem_op_e    op,
  input  logic [`LSU_XLEN-1:0]   address,
  input  logic [3:0]             byteenable,
  input  logic                   exception,
  input  rv_isa_pkg::exc_cause_e ecause,
  input  logic [`LSU_XLEN-1:0]   etval,
  input  logic [`LSU_XLEN-1:0]   lane_data,
  input  logic [`LSU_XLEN-1:0]   load_value,
  output lsu_pkg::access_size_e  size,
  output logic [1:0]             offset,
  output lsu_pkg::access_size_e  reg_size,
  output logic                   reg_unsigned,
  output logic [1:0]             reg_offset,
  output logic                   ram_we,
  output logic [3:0]             ram_be,
  output logic                   ram_re,
  output logic [`LSU_RAM_AW-1:0] ram_addr,
  output logic [`LSU_XLEN-1:0]   ram_wdata
);
  import rv_isa_pkg::*;
  import lsu_pkg::*;

  lsu_state_e state;
  logic       accept;
  logic       is_load;
  logic       is_store;
  logic       is_jump;
  logic       dec_unsigned;

  always_comb begin
    is_load = op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    is_store = op inside {op_sb, op_sh, op_sw};
    is_jump = op inside {op_jal, op_jalr, op_branch, op_auipc};
    dec_unsigned = op inside {op_lbu, op_lhu};
    case (op)
      op_lb, op_lbu, op_sb: size = size_byte;
      op_lh, op_lhu, op_sh: size = size_half;
      default: size = size_word;
    endcase
  end

  assign req_ready = (state == st_idle);
  assign rsp_valid = (state == st_resp);
  assign accept = req_valid & req_ready;
  assign offset = address[1:0];

  // ram access fires on the accepting edge, never on a misaligned request
  assign ram_we = accept & is_store & ~exception;
  assign ram_re = accept & is_load & ~exception;
  assign ram_be = byteenable;
  assign ram_addr = address[`LSU_RAM_AW+1:2];
  assign ram_wdata = lane_data;

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= (is_load && !exception) ? st_read : st_resp;
          end
        end
        st_read: state <= st_resp;
        st_resp: begin
          if (rsp_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      reg_size <= size;
      reg_unsigned <= dec_unsigned;
      reg_offset <= address[1:0];
      rsp_exception <= exception;
      rsp_ecause <= ecause;
      rsp_etval <= etval;
      // stores and faults return zero
      rsp_value <= (is_jump && !exception) ? address : '0;
    end
    if (state == st_read) begin
      rsp_value <= load_value;
    end
  end

endmodule

// ==== design/data_ram.sv ====
`timescale 1ns/100ps
`include "lsu_config.svh"

module data_ram (
  input  logic                   clock,
  input  logic                   we,
  input  logic [3:0]             byteenable,
  input  logic                   re,
  input  logic [`LSU_RAM_AW-1:0] addr,
  input  logic [`LSU_XLEN-1:0]   wdata,
  output logic [`LSU_XLEN-1:0]   rdata
);

  logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];

  always_ff @(posedge clock) begin
    if (we) begin
      for (int i = 0; i < 4; i++) begin
        if (byteenable[i]) begin
          mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
    // read data lands one edge later
    if (re) begin
      rdata <= mem[addr];
    end
  end

endmodule

// ==== design/load_extend.sv ====
`timescale 1ns/100ps
`include "lsu_config.svh"

module load_extend (
  input  lsu_pkg::access_size_e size,
  input  logic                  is_unsigned,
  input  logic [1:0]            offset,
  input  logic [`LSU_XLEN-1:0]  rdata,
  output logic [`LSU_XLEN-1:0]  value
);
  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0] shifted;
  logic                 ext;

  always_comb begin
    // addressed lane down to bit 0
    shifted = rdata >> {offset, 3'b000};
    ext = 1'b0;
    case (size)
      size_byte: begin
        ext = ~is_unsigned & shifted[7];
        value = {{(`LSU_XLEN-8){ext}}, shifted[7:0]};
      end
      size_half: begin
        ext = ~is_unsigned & shifted[15];
        value = {{(`LSU_XLEN-16){ext}}, shifted[15:0]};
      end
      default: begin
        value = rdata;
      end
    endcase
  end

endmodule

// ==== design/store_align.sv ====
`timescale 1ns/100ps
`include "lsu_config.svh"

module store_align (
  input  lsu_pkg::access_size_e size,
  input  logic [1:0]            offset,
  input  logic [`LSU_XLEN-1:0]  wdata,
  output logic [`LSU_XLEN-1:0]  lane_data
);
  import lsu_pkg::*;

  always_comb begin
    case (size)
      // lanes outside the byte enables are masked by the ram
      size_byte: begin
        lane_data = {{(`LSU_XLEN-8){1'b0}}, wdata[7:0]} << {offset, 3'b000};
      end
      size_half: begin
        lane_data = {{(`LSU_XLEN-16){1'b0}}, wdata[15:0]} << {offset[1], 4'b0000};
      end
      default: begin
        lane_data = wdata;
      end
    endcase
  end

endmodule

// ==== design/agu.sv ====
`timescale 1ns/100ps
`include "lsu_config.svh"

module agu (
  input  rv_isa_pkg::mem_op_e    op,
  input  logic [`LSU_XLEN-1:0]   pc,
  input  logic [`LSU_XLEN-1:0]   rs1,
  input  logic [`LSU_XLEN-1:0]   imm,
  output logic [`LSU_XLEN-1:0]   address,
  output logic [3:0]             byteenable,
  output logic                   exception,
  output rv_isa_pkg::exc_cause_e ecause,
  output logic [`LSU_XLEN-1:0]   etval
);
  import rv_isa_pkg::*;

  logic                 misalign;
  logic                 is_load;
  logic                 is_store;
  logic [`LSU_XLEN-1:0] base;

  always_comb begin
    is_load = op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    is_store = op inside {op_sb, op_sh, op_sw};

    // pc relative for jal, branch and auipc
    base = (op inside {op_jal, op_branch, op_auipc}) ? pc : rs1;
    address = base + imm;
    if (op == op_jalr) begin
      address[0] = 1'b0;
    end

    misalign = 1'b0;
    byteenable = 4'b0000;
    case (op)
      op_lb, op_lbu, op_sb: begin
        byteenable = 4'b0001 << address[1:0];
      end
      op_lh, op_lhu, op_sh: begin
        misalign = address[0];
        byteenable = address[1] ? 4'b1100 : 4'b0011;
      end
      op_lw, op_sw, op_jal, op_jalr, op_branch: begin
        misalign = |address[1:0];
        byteenable = 4'b1111;
      end
      default: begin
        byteenable = 4'b0000;
      end
    endcase
    if (misalign) begin
      byteenable = 4'b0000;
    end

    // jump targets keep the instruction misalign cause
    exception = misalign;
    ecause = exc_instr_misalign;
    etval = '0;
    if (misalign) begin
      etval = address;
      if (is_load) begin
        ecause = exc_load_misalign;
      end else if (is_store) begin
        ecause = exc_store_misalign;
      end
    end
  end

endmodule

// ==== design/lsu_pkg.sv ====
package lsu_pkg;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_e;

  // one request in flight, loads pass through st_read
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_read = 2'd1,
    st_resp = 2'd2
  } lsu_state_e;

endpackage

// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // request operations seen by the memory stage
  typedef enum logic [3:0] {
    op_lb     = 4'd0,
    op_lh     = 4'd1,
    op_lw     = 4'd2,
    op_lbu    = 4'd3,
    op_lhu    = 4'd4,
    op_sb     = 4'd5,
    op_sh     = 4'd6,
    op_sw     = 4'd7,
    op_jal    = 4'd8,
    op_jalr   = 4'd9,
    op_branch = 4'd10,
    op_auipc  = 4'd11
  } mem_op_e;

  // mcause codes for address misalignment
  typedef enum logic [3:0] {
    exc_instr_misalign = 4'd0,
    exc_load_misalign  = 4'd4,
    exc_store_misalign = 4'd6
  } exc_cause_e;

endpackage

// ==== design/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data and address width
`define LSU_XLEN 32

// ram geometry in words
`define LSU_RAM_WORDS 256
`define LSU_RAM_AW 8

`endif
